//--- Bender.yml
package:
  name: quark_core

export_include_dirs:
  - .

sources:
  - quarkPkg.sv
  - quarkControl.sv
  - quarkShifter.sv
  - quarkRegFile.sv
  - quarkExecute.sv
  - quarkCore.sv
  - target: test
    files:
      - tbQuarkCore.sv

//--- build.f
+incdir+.
quarkPkg.sv
quarkControl.sv
quarkShifter.sv
quarkRegFile.sv
quarkExecute.sv
quarkCore.sv
tbQuarkCore.sv

//--- quarkControl.sv
// Quark fetch/execute FSM, produces the fetch, latch, execute and write-back strobes
`timescale 1ns/10ps
`default_nettype none

module quarkControl (
   input  wire                 clk,
   input  wire                 reset,
   input  quarkPkg::opcode     op,
   input  wire                 isShift,
   input  wire                 shiftBusy,
   input  wire                 rbusy,
   input  wire                 wbusy,
   output logic                fetch,
   output logic                latch,
   output logic                exec,
   output logic                writeBack
);
   import quarkPkg::*;

   coreState state;

   // Opcodes that write rd
   logic opWrites;
   // Opcodes that must wait for the shifter or the memory
   logic needWait;

   assign opWrites = (op == aluImm) || (op == aluReg) || (op == lui);
   assign needWait = (op == store) || isShift;

   // Strobes decoded from the state
   assign fetch = (state == fetchInstr);
   // Instruction word valid once rbusy drops
   assign latch = (state == waitInstr) && !rbusy;
   assign exec  = (state == execute);

   // Shift results are written while waiting, the last write lands as shiftBusy falls
   assign writeBack = opWrites &&
                      (((state == execute) && !isShift) || (state == waitAluOrMem));

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by waiting for the memory to be ready for writes
         state <= waitAluOrMem;
      end else begin
         case (state)
            fetchInstr: state <= waitInstr;
            waitInstr: begin
               if (!rbusy) begin
                  state <= execute;
               end
            end
            execute: state <= needWait ? waitAluOrMem : fetchInstr;
            // waitAluOrMem
            default: begin
               if (!shiftBusy && !wbusy) begin
                  state <= fetchInstr;
               end
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- quarkCore.sv
// Quark core top, connects FSM, shifter, register file and datapath to the memory port
`timescale 1ns/10ps
`default_nettype none

`include "quark_defs.svh"

module quarkCore (
   input  wire                 clk,
   input  wire                 reset,
   output quarkPkg::memReq     memOut,
   input  quarkPkg::memRsp     memIn
);
   import quarkPkg::*;

   // Decode results
   opcode                  op;
   aluFunct                funct;
   logic                   isShift;
   logic                   arith;
   logic [4:0]             rd;
   // FSM strobes
   logic                   fetch, latch, exec, writeBack;
   // Shifter handshake
   logic                   shiftStart, shiftBusy;
   logic [4:0]             shiftAmount;
   logic [`QUARK_XLEN-1:0] shiftResult;
   // Operands and write-back value
   logic [`QUARK_XLEN-1:0] rs1, rs2, wbData;

   quarkControl quarkControl_inst (
      .clk(clk), .reset(reset), .op(op), .isShift(isShift),
      .shiftBusy(shiftBusy), .rbusy(memIn.rbusy), .wbusy(memIn.wbusy),
      .fetch(fetch), .latch(latch), .exec(exec), .writeBack(writeBack)
   );

   quarkShifter quarkShifter_inst (
      .clk(clk), .reset(reset), .start(shiftStart), .operand(rs1),
      .amount(shiftAmount), .funct(funct), .arith(arith),
      .result(shiftResult), .shiftBusy(shiftBusy)
   );

   // Same rdata word feeds operand fetch and the instruction register
   quarkRegFile quarkRegFile_inst (
      .clk(clk), .latch(latch), .fetched(memIn.rdata), .writeBack(writeBack),
      .rd(rd), .wdata(wbData), .rs1(rs1), .rs2(rs2)
   );

   quarkExecute quarkExecute_inst (
      .clk(clk), .reset(reset), .latch(latch), .exec(exec), .fetch(fetch),
      .fetched(memIn.rdata), .rs1(rs1), .rs2(rs2), .shiftResult(shiftResult),
      .op(op), .isShift(isShift), .funct(funct), .arith(arith),
      .shiftStart(shiftStart), .shiftAmount(shiftAmount), .rd(rd),
      .wbData(wbData), .mem(memOut)
   );

endmodule

`default_nettype wire

//--- quarkExecute.sv
// Quark datapath: instruction register, decode, ALU, PC and memory request
`timescale 1ns/10ps
`default_nettype none

`include "quark_defs.svh"

module quarkExecute (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      latch,
   input  wire                      exec,
   input  wire                      fetch,
   input  wire  [`QUARK_XLEN-1:0]   fetched,
   input  wire  [`QUARK_XLEN-1:0]   rs1,
   input  wire  [`QUARK_XLEN-1:0]   rs2,
   input  wire  [`QUARK_XLEN-1:0]   shiftResult,
   output quarkPkg::opcode          op,
   output logic                     isShift,
   output quarkPkg::aluFunct        funct,
   output logic                     arith,
   output logic                     shiftStart,
   output logic [4:0]               shiftAmount,
   output logic [4:0]               rd,
   output logic [`QUARK_XLEN-1:0]   wbData,
   output quarkPkg::memReq          mem
);
   import quarkPkg::*;

   localparam int AW = `QUARK_ADDR_WIDTH;

   // Bits 1:0 are always 11 in RV32I, not stored
   logic [31:2]                 instr;
   logic [AW-1:0]               pc;
   logic [AW-1:0]               storeAddr;
   // Set from fetch until the word is latched, selects PC on the address bus
   logic                        instrPending;
   logic                        isAlu;
   logic [`QUARK_XLEN-1:0]      iImm, sImm, uImm;
   logic [`QUARK_XLEN-1:0]      aluIn2, aluOut;
   logic [`QUARK_XLEN:0]        aluMinus;
   logic                        lt, ltu;

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Cleared word decodes as other, so nothing is written after reset
         instr        <= '0;
         pc           <= AW'(`QUARK_RESET_ADDR);
         instrPending <= 1'b0;
      end else begin
         if (latch) begin
            instr <= fetched[31:2];
         end
         if (exec) begin
            pc <= pc + AW'(4);
         end
         if (fetch) begin
            instrPending <= 1'b1;
         end else if (latch) begin
            instrPending <= 1'b0;
         end
      end
   end

   // Major opcode, unknown ones fold into other
   always_comb begin
      case (instr[6:2])
         5'b00100: op = aluImm;
         5'b01100: op = aluReg;
         5'b01101: op = lui;
         5'b01000: op = store;
         default:  op = other;
      endcase
   end

   assign funct       = aluFunct'(instr[14:12]);
   assign arith       = instr[30];
   assign rd          = instr[11:7];
   assign isAlu       = (op == aluImm) || (op == aluReg);
   assign isShift     = isAlu && ((funct == sll) || (funct == srlSra));
   assign shiftStart  = exec && isAlu;
   assign shiftAmount = aluIn2[4:0];

   // Immediate formats
   assign iImm = {{21{instr[31]}}, instr[30:20]};
   assign sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign uImm = {instr[31:12], 12'b0};

   // Second operand is rs2 only for register-register ops
   assign aluIn2   = (op == aluReg) ? rs2 : iImm;
   // One subtractor serves SUB, SLT and SLTU
   assign aluMinus = {1'b0, rs1} - {1'b0, aluIn2};
   assign ltu      = aluMinus[`QUARK_XLEN];
   assign lt       = (rs1[`QUARK_XLEN-1] ^ aluIn2[`QUARK_XLEN-1]) ?
                     rs1[`QUARK_XLEN-1] : ltu;

   always_comb begin
      case (funct)
         // SUB only for register-register, bit 30 belongs to the immediate otherwise
         addSub:  aluOut = ((op == aluReg) && instr[30]) ? aluMinus[`QUARK_XLEN-1:0] :
                           rs1 + aluIn2;
         slt:     aluOut = {{(`QUARK_XLEN-1){1'b0}}, lt};
         sltu:    aluOut = {{(`QUARK_XLEN-1){1'b0}}, ltu};
         xorOp:   aluOut = rs1 ^ aluIn2;
         orOp:    aluOut = rs1 | aluIn2;
         andOp:   aluOut = rs1 & aluIn2;
         default: aluOut = shiftResult;
      endcase
   end

   assign wbData    = (op == lui) ? uImm : aluOut;
   assign storeAddr = rs1[AW-1:0] + sImm[AW-1:0];

   // Memory request, PC during fetch and wait, store address otherwise
   always_comb begin
      mem.addr  = {{(`QUARK_XLEN-AW){1'b0}}, (fetch || instrPending) ? pc : storeAddr};
      mem.wdata = rs2;
      mem.wmask = {`QUARK_NBYTES{exec && (op == store)}};
      mem.rstrb = fetch;
   end

endmodule

`default_nettype wire

//--- quarkPkg.sv
// Quark shared types: FSM states, opcodes, ALU functions and memory-port structs
`default_nettype none

`include "quark_defs.svh"

package quarkPkg;

   // Fetch/execute FSM states
   typedef enum logic [1:0] {
      fetchInstr,
      waitInstr,
      execute,
      waitAluOrMem
   } coreState;

   // Major opcodes, instruction bits 6..2
   // Anything not listed decodes as other and runs as a no-op
   typedef enum logic [4:0] {
      aluImm = 5'b00100,
      store  = 5'b01000,
      aluReg = 5'b01100,
      lui    = 5'b01101,
      other  = 5'b11111
   } opcode;

   // ALU function, funct3 field
   typedef enum logic [2:0] {
      addSub = 3'b000,
      sll    = 3'b001,
      slt    = 3'b010,
      sltu   = 3'b011,
      xorOp  = 3'b100,
      srlSra = 3'b101,
      orOp   = 3'b110,
      andOp  = 3'b111
   } aluFunct;

   // Core to memory, 69 bits
   typedef struct packed {
      logic [`QUARK_XLEN-1:0]   addr;
      logic [`QUARK_XLEN-1:0]   wdata;
      logic [`QUARK_NBYTES-1:0] wmask;
      logic                     rstrb;
   } memReq;

   // Memory to core, 34 bits
   typedef struct packed {
      logic [`QUARK_XLEN-1:0] rdata;
      logic                   rbusy;
      logic                   wbusy;
   } memRsp;

endpackage

`default_nettype wire

//--- quarkRegFile.sv
// Quark register file, 32 entries, both operands read when the instruction is latched
`timescale 1ns/10ps
`default_nettype none

`include "quark_defs.svh"

module quarkRegFile (
   input  wire                      clk,
   input  wire                      latch,
   input  wire  [`QUARK_XLEN-1:0]   fetched,
   input  wire                      writeBack,
   input  wire  [4:0]               rd,
   input  wire  [`QUARK_XLEN-1:0]   wdata,
   output logic [`QUARK_XLEN-1:0]   rs1,
   output logic [`QUARK_XLEN-1:0]   rs2
);

   logic [`QUARK_XLEN-1:0] regs [0:`QUARK_NREGS-1];
   // Source indices straight from the incoming word
   logic [4:0]             rs1Id;
   logic [4:0]             rs2Id;

   assign rs1Id = fetched[19:15];
   assign rs2Id = fetched[24:20];

   // x0 is never written
   always_ff @(posedge clk) begin
      if (writeBack && (rd != 5'd0)) begin
         regs[rd] <= wdata;
      end
   end

   // Operand latch, x0 forced to zero on read
   always_ff @(posedge clk) begin
      if (latch) begin
         rs1 <= (rs1Id == 5'd0) ? '0 : regs[rs1Id];
         rs2 <= (rs2Id == 5'd0) ? '0 : regs[rs2Id];
      end
   end

endmodule

`default_nettype wire

//--- quarkShifter.sv
// Quark serial shifter, one bit per cycle with a down-counter for the remaining amount
`timescale 1ns/10ps
`default_nettype none

`include "quark_defs.svh"

module quarkShifter (
   input  wire                      clk,
   input  wire                      reset,
   input  wire                      start,
   input  wire  [`QUARK_XLEN-1:0]   operand,
   input  wire  [4:0]               amount,
   input  quarkPkg::aluFunct        funct,
   input  wire                      arith,
   output logic [`QUARK_XLEN-1:0]   result,
   output logic                     shiftBusy
);
   import quarkPkg::*;

   logic [`QUARK_XLEN-1:0] shiftReg;
   // Remaining shift steps
   logic [4:0]             count;
   logic                   isShiftFunct;

   assign isShiftFunct = (funct == sll) || (funct == srlSra);
   assign shiftBusy    = |count;
   assign result       = shiftReg;

   // Counter is control state
   always_ff @(posedge clk) begin
      if (!reset) begin
         count <= '0;
      end else if (start && isShiftFunct) begin
         count <= amount;
      end else if (shiftBusy) begin
         count <= count - 5'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (start && isShiftFunct) begin
         shiftReg <= operand;
      end else if (shiftBusy) begin
         // SLL moves left, SRL fills zero, SRA fills with the sign bit
         shiftReg <= (funct == sll) ? {shiftReg[`QUARK_XLEN-2:0], 1'b0} :
                     {arith & shiftReg[`QUARK_XLEN-1], shiftReg[`QUARK_XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

//--- quark_defs.svh
// Quark core constants: address width, reset address, word width and register count
`ifndef QUARK_DEFS_SVH
`define QUARK_DEFS_SVH

// Internal address width
// PC and store address adders are this wide
`define QUARK_ADDR_WIDTH 24

// Address of the first instruction fetch after reset
`define QUARK_RESET_ADDR 0

// Data word width, RV32
`define QUARK_XLEN 32

// Number of integer registers, x0 included
`define QUARK_NREGS 32

// Bytes per word, one write-mask bit per byte
`define QUARK_NBYTES (`QUARK_XLEN / 8)

`endif

//--- tbQuarkModel.svh
// Quark reference model: architectural registers, ISA execution and instruction encoders
`ifndef TB_QUARK_MODEL_SVH
`define TB_QUARK_MODEL_SVH

// Architectural registers, x0 stays zero
logic [31:0] modelRegs [0:31];

// R-type ALU word, opcode OP
function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
   return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

// I-type ALU word, opcode OP-IMM
function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
   return {imm, rs1, f3, rd, 7'h13};
endfunction

// SW word, funct3 010
function automatic logic [31:0] storeWord(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] luiWord(input logic [19:0] imm, input logic [4:0] rd);
   return {imm, rd, 7'h37};
endfunction

task automatic clearModel();
   int i;
   for (i = 0; i < 32; i++) begin
      modelRegs[i] = '0;
   end
endtask

// Runs one instruction on the model, reports the write a store makes
task automatic modelExecute(input logic [31:0] instr, output logic isStore,
                            output logic [31:0] sAddr, output logic [31:0] sData,
                            output int shiftAmt);
   logic [31:0]        a;
   logic [31:0]        b;
   logic [31:0]        res;
   logic [31:0]        sImm;
   logic signed [31:0] sa;
   logic [2:0]         f3;
   logic               isReg;
   logic               wr;
   f3       = instr[14:12];
   isReg    = (instr[6:0] == 7'h33);
   a        = modelRegs[instr[19:15]];
   // Second operand is rs2 or the sign-extended I immediate
   b        = isReg ? modelRegs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
   sImm     = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   sa       = a;
   isStore  = 1'b0;
   sAddr    = '0;
   sData    = '0;
   shiftAmt = -1;
   wr       = 1'b0;
   res      = '0;
   case (instr[6:0])
      7'h13, 7'h33: begin
         wr = 1'b1;
         case (f3)
            3'd0: res = (isReg && instr[30]) ? a - b : a + b;
            3'd1: res = a << b[4:0];
            3'd2: res = {31'b0, $signed(a) < $signed(b)};
            3'd3: res = {31'b0, a < b};
            3'd4: res = a ^ b;
            3'd5: begin
               // Bit 30 picks arithmetic right shift
               if (instr[30]) begin
                  res = sa >>> b[4:0];
               end else begin
                  res = a >> b[4:0];
               end
            end
            3'd6: res = a | b;
            default: res = a & b;
         endcase
         if (f3 == 3'd1 || f3 == 3'd5) begin
            shiftAmt = b[4:0];
         end
      end
      7'h37: begin
         wr  = 1'b1;
         res = {instr[31:12], 12'b0};
      end
      7'h23: begin
         isStore = 1'b1;
         // Store address wraps at the internal address width
         sAddr   = (a + sImm) & ((32'd1 << `QUARK_ADDR_WIDTH) - 32'd1);
         sData   = modelRegs[instr[24:20]];
      end
      default: begin
      end
   endcase
   if (wr && (instr[11:7] != 5'd0)) begin
      modelRegs[instr[11:7]] = res;
   end
endtask

`endif

//--- tbQuarkCore.sv
// Quark core testbench, random program checked against a reference model behind a busy memory
`timescale 1ns/10ps
`default_nettype none

`include "quark_defs.svh"

module tbQuarkCore;
   import quarkPkg::*;

   localparam int NumInstr       = 60;
   localparam int ResetCycles    = 4;
   // Base cycle, longest shift and busy allowance per instruction
   localparam int CyclesPerInstr = 3 + 31 + 8;
   localparam int WatchdogCycles = ResetCycles + NumInstr * CyclesPerInstr;

   logic        clk;
   logic        reset;
   memReq       memOut;
   memRsp       memIn;
   integer      seed;
   logic [31:0] progMem [0:63];

   // Fetch tracking
   logic [31:0] expPc;
   int          fetchCount;
   logic        pending;
   logic [5:0]  pendingIdx;
   logic        running;
   logic        done;
   int          cycle;
   int          execCycle;
   int          lastShiftAmt;
   // Next fetch must see wbusy low first
   logic        waitBefore;
   // Cycles left with wbusy forced high
   int          holdCount;
   // Write expected from the store in flight
   logic        storeExpected;
   logic [31:0] expAddr;
   logic [31:0] expData;
   int          storeCount;
   int          valueErrors;
   int          otherErrors;

   `include "tbQuarkModel.svh"

   quarkCore quarkCore_inst (
      .clk(clk), .reset(reset), .memOut(memOut), .memIn(memIn)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic makeProgram();
      int          i;
      int          kind;
      logic [4:0]  rdR;
      logic [4:0]  rs1R;
      logic [4:0]  rs2R;
      logic [2:0]  f3;
      logic        alt;
      logic [11:0] imm;
      logic [19:0] upper;
      // x1..x7 get values first, the register file has no reset
      for (i = 0; i < 7; i++) begin
         imm = $random(seed);
         progMem[i] = iTypeWord(imm, 5'd0, 3'd0, 5'(i + 1));
      end
      for (i = 7; i < NumInstr; i++) begin
         kind  = $unsigned($random(seed)) % 10;
         rdR   = $random(seed) & 7;
         rs1R  = $random(seed) & 7;
         rs2R  = $random(seed) & 7;
         f3    = $random(seed);
         alt   = $random(seed);
         imm   = $random(seed);
         upper = $random(seed);
         if (kind < 3) begin
            progMem[i] = storeWord(imm, rs2R, rs1R);
         end else if (kind < 6) begin
            // Shift immediates hold only the amount and the arithmetic bit
            if (f3 == 3'd1 || f3 == 3'd5) begin
               imm = {1'b0, alt && (f3 == 3'd5), 5'b0, imm[4:0]};
            end
            progMem[i] = iTypeWord(imm, rs1R, f3, rdR);
         end else if (kind < 9) begin
            progMem[i] = rTypeWord({1'b0, alt && (f3 == 3'd0 || f3 == 3'd5), 5'b0},
                                   rs2R, rs1R, f3, rdR);
         end else begin
            progMem[i] = luiWord(upper, rdR);
         end
      end
      // Padding, a different ADDI to x0 per word
      for (i = NumInstr; i < 64; i++) begin
         progMem[i] = iTypeWord(12'(i), 5'd0, 3'd0, 5'd0);
      end
   endtask

   task automatic driveInputs();
      memIn.rbusy = $random(seed);
      if (holdCount > 0) begin
         memIn.wbusy = 1'b1;
         holdCount--;
      end else begin
         memIn.wbusy = $random(seed);
      end
      // Garbage on rdata unless the pending fetch is answered now
      memIn.rdata = $random(seed);
      if (pending && !memIn.rbusy) begin
         memIn.rdata = progMem[pendingIdx];
         pending     = 1'b0;
         // Latched at the next edge, executed in the cycle after
         execCycle   = cycle + 1;
      end
   endtask

   task automatic checkStore(input memReq s);
      if (!storeExpected) begin
         $display("Write at address %h with no store in flight", s.addr);
         otherErrors++;
      end else begin
         storeCount++;
         if (s.wmask != 4'hF) begin
            $display("ERR memOut.wmask got %h expected %h", s.wmask, 4'hF);
            valueErrors++;
         end
         if (s.addr != expAddr) begin
            $display("ERR memOut.addr got %h expected %h", s.addr, expAddr);
            valueErrors++;
         end
         if (s.wdata != expData) begin
            $display("ERR memOut.wdata got %h expected %h", s.wdata, expData);
            valueErrors++;
         end
      end
      storeExpected = 1'b0;
      // Hold write busy for a while after each store
      holdCount     = 1 + ($random(seed) & 3);
   endtask

   task automatic checkFetch(input logic [31:0] addr, input logic prevWbusy);
      logic        isStore;
      logic [31:0] sAddr;
      logic [31:0] sData;
      int          shiftAmt;
      if (waitBefore && prevWbusy) begin
         $display("Fetch started while write busy was still high");
         otherErrors++;
      end
      if (storeExpected) begin
         $display("Store before fetch of %h never wrote to memory", addr);
         otherErrors++;
         storeExpected = 1'b0;
      end
      if (lastShiftAmt >= 0 && (cycle - execCycle) <= lastShiftAmt) begin
         $display("Fetch came %0d cycles after a shift by %0d", cycle - execCycle,
                  lastShiftAmt);
         otherErrors++;
      end
      if (addr != expPc) begin
         $display("ERR memOut.addr got %h expected %h", addr, expPc);
         valueErrors++;
      end
      if (fetchCount == NumInstr) begin
         done = 1'b1;
      end else begin
         modelExecute(progMem[fetchCount], isStore, sAddr, sData, shiftAmt);
         storeExpected = isStore;
         expAddr       = sAddr;
         expData       = sData;
         lastShiftAmt  = shiftAmt;
         waitBefore    = isStore || (shiftAmt >= 0);
         pending       = 1'b1;
         pendingIdx    = 6'((addr - `QUARK_RESET_ADDR) >> 2);
         expPc         = expPc + 32'd4;
         fetchCount++;
      end
   endtask

   // Outputs are sampled before new inputs go out on the falling edge
   always @(negedge clk) begin
      memReq sampled;
      logic  prevWbusy;
      if (running && !done) begin
         cycle++;
         sampled   = memOut;
         prevWbusy = memIn.wbusy;
         driveInputs();
         if (sampled.wmask != '0) begin
            checkStore(sampled);
         end
         if (sampled.rstrb) begin
            checkFetch(sampled.addr, prevWbusy);
         end
      end
   end

   initial begin
      seed          = 55;
      reset         = 1'b0;
      memIn.rdata   = '0;
      memIn.rbusy   = 1'b0;
      memIn.wbusy   = 1'b1;
      expPc         = `QUARK_RESET_ADDR;
      fetchCount    = 0;
      pending       = 1'b0;
      pendingIdx    = '0;
      running       = 1'b0;
      done          = 1'b0;
      cycle         = 0;
      execCycle     = 0;
      lastShiftAmt  = -1;
      // Reset leaves the core waiting on write busy
      waitBefore    = 1'b1;
      holdCount     = 6;
      storeExpected = 1'b0;
      expAddr       = '0;
      expData       = '0;
      storeCount    = 0;
      valueErrors   = 0;
      otherErrors   = 0;
      makeProgram();
      clearModel();
      repeat (ResetCycles) @(posedge clk);
      @(negedge clk);
      reset = 1'b1;
      @(posedge clk);
      running = 1'b1;
      wait (done);
      $display("Fetches %0d, stores %0d, value errors %0d, other errors %0d",
               fetchCount, storeCount, valueErrors, otherErrors);
      if (valueErrors == 0 && otherErrors == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog
   initial begin
      repeat (WatchdogCycles) @(posedge clk);
      $display("Timeout after %0d cycles, %0d of %0d instructions fetched",
               WatchdogCycles, fetchCount, NumInstr);
      $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire
